/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  // Encoding width of the ALU operation
  localparam int alu_op_width = 2;

  // Operations the ALU can perform
  typedef enum logic [alu_op_width-1:0] {
    alu_add = 2'd0,
    alu_sub = 2'd1,
    alu_and = 2'd2,
    alu_or = 2'd3
  } alu_op_e;

  // Decode to execute record
  typedef struct packed {
    logic valid;
    alu_op_e alu_op;
    logic [rv_isa_pkg::xlen-1:0] operand_a;
    // Register value or sign-extended immediate
    logic [rv_isa_pkg::xlen-1:0] operand_b;
    // rs2 value, only meaningful for stores
    logic [rv_isa_pkg::xlen-1:0] store_data;
    logic [rv_isa_pkg::reg_index_width-1:0] rd;
    logic reg_write;
    logic mem_to_reg;
    logic mem_write;
  } id_ex_t;

  // Execute to memory record
  typedef struct packed {
    logic valid;
    // Also the effective address for loads and stores
    logic [rv_isa_pkg::xlen-1:0] alu_result;
    logic [rv_isa_pkg::xlen-1:0] store_data;
    logic [rv_isa_pkg::reg_index_width-1:0] rd;
    logic reg_write;
    logic mem_to_reg;
    logic mem_write;
  } ex_mem_t;

  // Memory to write-back record, also the top output
  typedef struct packed {
    logic valid;
    logic [rv_isa_pkg::reg_index_width-1:0] rd;
    logic [rv_isa_pkg::xlen-1:0] data;
  } mem_wb_t;

endpackage

`default_nettype wire

/* common/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // Datapath and register file sizes
  localparam int xlen = 32;
  localparam int reg_index_width = 5;

  // Word data memory, addressed by word
  localparam int dmem_depth = 256;
  localparam int dmem_addr_width = 8;

  // Major opcodes of the supported subset
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  // ADD and SUB share funct3 and differ in funct7
  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_and = 3'b111;
  localparam logic [2:0] funct3_or = 3'b110;
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_sub = 7'b0100000;

  // R format: register to register operations
  typedef struct packed {
    logic [6:0] funct7;
    logic [reg_index_width-1:0] rs2;
    logic [reg_index_width-1:0] rs1;
    logic [2:0] funct3;
    logic [reg_index_width-1:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  // I format: ADDI and LW, 12-bit signed immediate
  typedef struct packed {
    logic [11:0] imm;
    logic [reg_index_width-1:0] rs1;
    logic [2:0] funct3;
    logic [reg_index_width-1:0] rd;
    logic [6:0] opcode;
  } i_fields_t;

  // S format: the store offset is split around rs2 and rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [reg_index_width-1:0] rs2;
    logic [reg_index_width-1:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fields_t;

  // One instruction word, three ways to read it
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    s_fields_t s;
  } instr_u;

endpackage

`default_nettype wire

/* core_pipeline.f */
common/rv_isa_pkg.sv
common/pipe_pkg.sv
execute/alu.sv
execute/ex_mem_register.sv
src/register_file.sv
src/decode_stage.sv
src/memory_stage.sv
src/core_pipeline.sv
dv/core_pipeline_properties.sv
dv/core_pipeline_tb.sv

/* dv/core_pipeline_properties.sv */
`default_nettype none
`timescale 1ns/1ns

module core_pipeline_properties (
  input logic clk,
  input logic reset,
  input logic instr_valid,
  input logic id_ex_valid,
  input logic ex_mem_valid,
  input logic wb_valid
);

  // A write-back always traces back to an issue three edges earlier
  wb_follows_issue: assert property (
    @(posedge clk) disable iff (reset) wb_valid |-> $past(instr_valid, 3)
  ) else $error("wb.valid high without an issue three cycles earlier");

  // Execute register only fills from a live decode record
  ex_mem_follows_id_ex: assert property (
    @(posedge clk) disable iff (reset) ex_mem_valid |-> $past(id_ex_valid)
  ) else $error("ex_mem.valid high without id_ex.valid one cycle earlier");

  // Output quiet right after a reset edge
  wb_quiet_after_reset: assert property (
    @(posedge clk) reset |=> !wb_valid
  ) else $error("wb.valid high in the cycle after reset");

endmodule

bind core_pipeline core_pipeline_properties u_properties (
  .clk          (clk),
  .reset        (reset),
  .instr_valid  (instr_valid),
  .id_ex_valid  (id_ex.valid),
  .ex_mem_valid (ex_mem.valid),
  .wb_valid     (wb.valid)
);

`default_nettype wire

/* dv/core_pipeline_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module core_pipeline_tb;

  localparam int clk_period = 100;
  localparam int reset_cycles = 3;
  localparam int hazard_gap = 4;
  localparam int random_count = 40;
  localparam int directed_ops = 45;
  // Each op with its spacing, plus room to drain
  localparam int timeout_cycles = reset_cycles + (directed_ops + random_count) * hazard_gap + 40;

  // One predicted write-back and the cycle it is due
  typedef struct packed {
    logic [31:0] due;
    logic [4:0] rd;
    logic [31:0] data;
  } expected_wb_t;

  logic clk = 1'b0;
  logic reset;
  logic instr_valid;
  rv_isa_pkg::instr_u instr;
  pipe_pkg::mem_wb_t wb;

  // Reference state
  logic [31:0] model_regs [32];
  logic [31:0] model_mem [256];
  expected_wb_t expected_q [$];
  pipe_pkg::mem_wb_t seen_q [$];
  logic [31:0] cycle_count = '0;
  int issue_gap;
  int seed;
  int error_count;

  core_pipeline UUT (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb)
  );

  initial
  begin
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 32'd1;
  end

  task automatic stop_with_failure(input string reason);
    error_count++;
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      stop_with_failure($sformatf("Error: time %0t signal %s actual %h expected %h",
                                  $time, name, actual, expected));
    end
  endtask

  function automatic logic [31:0] sign_extend_imm(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // I format for ADDI and LW, the store split is handled separately
  function automatic rv_isa_pkg::instr_u encode_i_type(input logic [6:0] opcode,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    rv_isa_pkg::instr_u word;
    word.i.opcode = opcode;
    word.i.rd = rd;
    word.i.funct3 = (opcode == rv_isa_pkg::opcode_load) ? 3'b010 : 3'b000;
    word.i.rs1 = rs1;
    word.i.imm = imm;
    return word;
  endfunction

  // Drive for one cycle, then hold off for the spacing in force
  task automatic issue(input rv_isa_pkg::instr_u word);
    instr_valid = 1'b1;
    instr = word;
    @(negedge clk);
    instr_valid = 1'b0;
    repeat (issue_gap) @(negedge clk);
  endtask

  // x0 targets are dropped, nothing expected on wb
  task automatic expect_write(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0)
    begin
      model_regs[rd] = value;
      expected_q.push_back('{due: cycle_count + 32'd3, rd: rd, data: value});
    end
  endtask

  task automatic do_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    expect_write(rd, model_regs[rs1] + sign_extend_imm(imm));
    issue(encode_i_type(rv_isa_pkg::opcode_op_imm, rd, rs1, imm));
  endtask

  task automatic do_rtype(input pipe_pkg::alu_op_e op, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
    rv_isa_pkg::instr_u word;
    logic [31:0] value;
    word.r.funct7 = rv_isa_pkg::funct7_base;
    word.r.funct3 = rv_isa_pkg::funct3_add_sub;
    case (op)
      pipe_pkg::alu_sub:
      begin
        word.r.funct7 = rv_isa_pkg::funct7_sub;
        value = model_regs[rs1] - model_regs[rs2];
      end
      pipe_pkg::alu_and:
      begin
        word.r.funct3 = rv_isa_pkg::funct3_and;
        value = model_regs[rs1] & model_regs[rs2];
      end
      pipe_pkg::alu_or:
      begin
        word.r.funct3 = rv_isa_pkg::funct3_or;
        value = model_regs[rs1] | model_regs[rs2];
      end
      default: value = model_regs[rs1] + model_regs[rs2];
    endcase
    word.r.rs2 = rs2;
    word.r.rs1 = rs1;
    word.r.rd = rd;
    word.r.opcode = rv_isa_pkg::opcode_op;
    expect_write(rd, value);
    issue(word);
  endtask

  task automatic do_store(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
    rv_isa_pkg::instr_u word;
    logic [31:0] addr;
    addr = model_regs[rs1] + sign_extend_imm(imm);
    model_mem[addr[9:2]] = model_regs[rs2];
    word.s.imm_hi = imm[11:5];
    word.s.rs2 = rs2;
    word.s.rs1 = rs1;
    word.s.funct3 = 3'b010;
    word.s.imm_lo = imm[4:0];
    word.s.opcode = rv_isa_pkg::opcode_store;
    issue(word);
  endtask

  task automatic do_load(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] addr;
    addr = model_regs[rs1] + sign_extend_imm(imm);
    expect_write(rd, model_mem[addr[9:2]]);
    issue(encode_i_type(rv_isa_pkg::opcode_load, rd, rs1, imm));
  endtask

  // Every wb is matched in order against the model, on its due cycle
  always @(negedge clk)
  begin : wb_monitor
    pipe_pkg::mem_wb_t got;
    expected_wb_t want;
    if (!reset)
    begin
      if (wb.valid)
        seen_q.push_back(wb);
      while (seen_q.size() > 0)
      begin
        got = seen_q.pop_front();
        if (expected_q.size() == 0)
        begin
          stop_with_failure($sformatf("Unexpected write-back to x%0d at %0t", got.rd, $time));
        end
        else
        begin
          want = expected_q.pop_front();
          check_value("wb cycle", cycle_count, want.due);
          check_value("wb.rd", 32'(got.rd), 32'(want.rd));
          check_value("wb.data", got.data, want.data);
        end
      end
      if (expected_q.size() > 0 && expected_q[0].due < cycle_count)
        stop_with_failure($sformatf("Write-back to x%0d never arrived", expected_q[0].rd));
    end
  end

  task automatic test_reset_and_addi();
    repeat (6)
    begin
      check_value("wb.valid", 32'(wb.valid), 32'd0);
      @(negedge clk);
    end
    do_addi(5'd1, 5'd0, 12'h07b);
    // Negative and most negative immediates
    do_addi(5'd2, 5'd0, 12'hf9c);
    do_addi(5'd3, 5'd1, 12'h800);
  endtask

  task automatic test_rtype();
    do_addi(5'd4, 5'd0, 12'h5a3);
    do_addi(5'd5, 5'd0, 12'hedc);
    do_rtype(pipe_pkg::alu_add, 5'd6, 5'd4, 5'd5);
    do_rtype(pipe_pkg::alu_sub, 5'd7, 5'd4, 5'd5);
    do_rtype(pipe_pkg::alu_sub, 5'd8, 5'd5, 5'd4);
    do_rtype(pipe_pkg::alu_and, 5'd9, 5'd4, 5'd5);
    do_rtype(pipe_pkg::alu_or, 5'd10, 5'd4, 5'd5);
    do_rtype(pipe_pkg::alu_add, 5'd11, 5'd6, 5'd7);
  endtask

  task automatic test_back_to_back();
    issue_gap = 0;
    for (int i = 0; i < 8; i++)
      do_addi(5'(12 + i), 5'd0, 12'(i * 37 - 100));
    issue_gap = hazard_gap - 1;
    repeat (hazard_gap) @(negedge clk);
  endtask

  task automatic test_store_load();
    do_addi(5'd20, 5'd0, 12'h100);
    do_addi(5'd21, 5'd0, 12'h321);
    do_store(5'd21, 5'd20, 12'h008);
    do_load(5'd22, 5'd20, 12'h008);
    // Negative and large positive offsets
    do_store(5'd5, 5'd20, 12'hffc);
    do_load(5'd23, 5'd20, 12'hffc);
    do_store(5'd6, 5'd20, 12'h7f0);
    do_load(5'd24, 5'd20, 12'h7f0);
    // Same word through another base
    do_addi(5'd25, 5'd0, 12'h0f8);
    do_load(5'd26, 5'd25, 12'h010);
  endtask

  task automatic test_x0_and_unknown();
    do_addi(5'd0, 5'd0, 12'h037);
    do_rtype(pipe_pkg::alu_or, 5'd0, 5'd4, 5'd5);
    do_rtype(pipe_pkg::alu_add, 5'd27, 5'd0, 5'd0);
    // Reserved opcode, must not reach wb
    issue(encode_i_type(7'b1111111, 5'd28, 5'd4, 12'h001));
    do_addi(5'd28, 5'd0, 12'h000);
  endtask

  task automatic test_random();
    logic [31:0] pick;
    logic [31:0] fields;
    logic [4:0] rd;
    for (int n = 0; n < random_count; n++)
    begin
      pick = $random(seed);
      fields = $random(seed);
      rd = 5'(pick % 32'd31 + 32'd1);
      if (fields[31])
        do_addi(rd, fields[4:0], fields[21:10]);
      else
        do_rtype(pipe_pkg::alu_add, rd, fields[4:0], fields[9:5]);
    end
  endtask

  initial
  begin : watchdog
    #(timeout_cycles * clk_period);
    stop_with_failure($sformatf("Timeout, run exceeded %0d cycles", timeout_cycles));
  end

  initial
  begin
    seed = 80;
    error_count = 0;
    issue_gap = hazard_gap - 1;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_and_addi();
    test_rtype();
    test_back_to_back();
    test_store_load();
    test_x0_and_unknown();
    test_random();
    repeat (hazard_gap + 2) @(negedge clk);
    check_value("pending write-backs", 32'(expected_q.size()), 32'd0);
    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* execute/alu.sv */
`default_nettype none
`timescale 1ns/1ns

module alu (
  input  pipe_pkg::alu_op_e alu_op,
  input  logic [rv_isa_pkg::xlen-1:0] operand_a,
  input  logic [rv_isa_pkg::xlen-1:0] operand_b,
  output logic [rv_isa_pkg::xlen-1:0] result
);

  // Adder and subtractor results, picked below
  logic [rv_isa_pkg::xlen-1:0] sum;
  logic [rv_isa_pkg::xlen-1:0] difference;

  // Two's complement, carries out are dropped
  assign sum = operand_a + operand_b;
  assign difference = operand_a - operand_b;

  always_comb
  begin
    case (alu_op)
      pipe_pkg::alu_add:
      begin
        // ADD, ADDI and address generation
        result = sum;
      end
      pipe_pkg::alu_sub:
      begin
        result = difference;
      end
      pipe_pkg::alu_and:
      begin
        // Bitwise
        result = operand_a & operand_b;
      end
      pipe_pkg::alu_or:
      begin
        result = operand_a | operand_b;
      end
      default:
      begin
        result = sum;
      end
    endcase
  end

endmodule

`default_nettype wire

/* execute/ex_mem_register.sv */
`default_nettype none
`timescale 1ns/1ns

module ex_mem_register (
  input  logic clk,
  input  logic reset,
  input  pipe_pkg::id_ex_t id_ex,
  input  logic [rv_isa_pkg::xlen-1:0] alu_result,
  output pipe_pkg::ex_mem_t ex_mem
);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ex_mem.valid <= 1'b0;
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_to_reg <= 1'b0;
      ex_mem.mem_write <= 1'b0;
    end
    else if (id_ex.valid)
    begin
      // Capture result together with its controls
      ex_mem.valid <= 1'b1;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= id_ex.store_data;
      ex_mem.rd <= id_ex.rd;
      ex_mem.reg_write <= id_ex.reg_write;
      ex_mem.mem_to_reg <= id_ex.mem_to_reg;
      ex_mem.mem_write <= id_ex.mem_write;
    end
    else
    begin
      // Bubble, payload keeps its old value
      ex_mem.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the core_pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f core_pipeline.f --top-module core_pipeline_tb \
  -Mdir obj_dir > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vcore_pipeline_tb > sim.log 2>&1

grep -q 'Test failures found' sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* src/core_pipeline.sv */
`default_nettype none
`timescale 1ns/1ns

module core_pipeline (
  input  logic clk,
  input  logic reset,
  input  logic instr_valid,
  input  rv_isa_pkg::instr_u instr,
  output pipe_pkg::mem_wb_t wb
);

  // Register file read ports
  logic [rv_isa_pkg::reg_index_width-1:0] rs1_addr;
  logic [rv_isa_pkg::reg_index_width-1:0] rs2_addr;
  logic [rv_isa_pkg::xlen-1:0] rs1_data;
  logic [rv_isa_pkg::xlen-1:0] rs2_data;

  // Stage records
  pipe_pkg::id_ex_t id_ex;
  pipe_pkg::ex_mem_t ex_mem;

  // Combinational ALU output into the execute register
  logic [rv_isa_pkg::xlen-1:0] alu_result;

  // Decode, operands read in the same cycle
  decode_stage u_decode_stage (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .id_ex       (id_ex)
  );

  // Write port is fed straight from the top output
  register_file u_register_file (
    .clk          (clk),
    .reset        (reset),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .write_enable (wb.valid),
    .write_addr   (wb.rd),
    .write_data   (wb.data)
  );

  // Execute
  alu u_alu (
    .alu_op    (id_ex.alu_op),
    .operand_a (id_ex.operand_a),
    .operand_b (id_ex.operand_b),
    .result    (alu_result)
  );

  ex_mem_register u_ex_mem_register (
    .clk        (clk),
    .reset      (reset),
    .id_ex      (id_ex),
    .alu_result (alu_result),
    .ex_mem     (ex_mem)
  );

  // Data memory and write-back record
  memory_stage u_memory_stage (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .mem_wb (wb)
  );

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module decode_stage (
  input  logic clk,
  input  logic reset,
  input  logic instr_valid,
  input  rv_isa_pkg::instr_u instr,
  output logic [rv_isa_pkg::reg_index_width-1:0] rs1_addr,
  output logic [rv_isa_pkg::reg_index_width-1:0] rs2_addr,
  input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
  input  logic [rv_isa_pkg::xlen-1:0] rs2_data,
  output pipe_pkg::id_ex_t id_ex
);

  // Decoded controls of the word on the input
  logic known;
  logic use_imm;
  logic reg_write;
  logic mem_to_reg;
  logic mem_write;
  pipe_pkg::alu_op_e alu_op;
  logic [11:0] imm12;
  logic [rv_isa_pkg::xlen-1:0] imm_ext;

  // rs1 and rs2 sit at the same bits in every format
  assign rs1_addr = instr.r.rs1;
  assign rs2_addr = instr.r.rs2;

  always_comb
  begin
    known = 1'b0;
    use_imm = 1'b0;
    reg_write = 1'b0;
    mem_to_reg = 1'b0;
    mem_write = 1'b0;
    alu_op = pipe_pkg::alu_add;
    imm12 = instr.i.imm;
    case (instr.r.opcode)
      rv_isa_pkg::opcode_op:
      begin
        known = 1'b1;
        reg_write = (instr.r.rd != '0);
        // funct7 and funct3 together select the operation
        case ({instr.r.funct7, instr.r.funct3})
          {rv_isa_pkg::funct7_base, rv_isa_pkg::funct3_add_sub}: alu_op = pipe_pkg::alu_add;
          {rv_isa_pkg::funct7_sub, rv_isa_pkg::funct3_add_sub}: alu_op = pipe_pkg::alu_sub;
          {rv_isa_pkg::funct7_base, rv_isa_pkg::funct3_and}: alu_op = pipe_pkg::alu_and;
          {rv_isa_pkg::funct7_base, rv_isa_pkg::funct3_or}: alu_op = pipe_pkg::alu_or;
          // Unsupported R-type becomes a bubble
          default: known = 1'b0;
        endcase
      end
      rv_isa_pkg::opcode_op_imm:
      begin
        known = 1'b1;
        use_imm = 1'b1;
        reg_write = (instr.i.rd != '0);
      end
      rv_isa_pkg::opcode_load:
      begin
        // Address is rs1 plus the I offset
        known = 1'b1;
        use_imm = 1'b1;
        reg_write = (instr.i.rd != '0);
        mem_to_reg = 1'b1;
      end
      rv_isa_pkg::opcode_store:
      begin
        known = 1'b1;
        use_imm = 1'b1;
        mem_write = 1'b1;
        imm12 = {instr.s.imm_hi, instr.s.imm_lo};
      end
      default: known = 1'b0;
    endcase
  end

  // Sign extension of the 12-bit immediate
  assign imm_ext = {{(rv_isa_pkg::xlen - 12){imm12[11]}}, imm12};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      id_ex.valid <= 1'b0;
      id_ex.reg_write <= 1'b0;
      id_ex.mem_to_reg <= 1'b0;
      id_ex.mem_write <= 1'b0;
    end
    else if (instr_valid)
    begin
      // Unknown opcode leaves valid low
      id_ex.valid <= known;
      id_ex.alu_op <= alu_op;
      id_ex.operand_a <= rs1_data;
      id_ex.operand_b <= use_imm ? imm_ext : rs2_data;
      id_ex.store_data <= rs2_data;
      id_ex.rd <= instr.r.rd;
      id_ex.reg_write <= reg_write;
      id_ex.mem_to_reg <= mem_to_reg;
      id_ex.mem_write <= mem_write;
    end
    else
    begin
      id_ex.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/memory_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module memory_stage (
  input  logic clk,
  input  logic reset,
  input  pipe_pkg::ex_mem_t ex_mem,
  output pipe_pkg::mem_wb_t mem_wb
);

  // Word index taken from the byte address
  logic [rv_isa_pkg::dmem_addr_width-1:0] word_addr;
  logic [rv_isa_pkg::xlen-1:0] dmem [rv_isa_pkg::dmem_depth];

  // Bits 9:2, low two bits ignored for word accesses
  assign word_addr = ex_mem.alu_result[rv_isa_pkg::dmem_addr_width+1:2];

  // Store port
  always_ff @(posedge clk)
  begin
    if (ex_mem.valid && ex_mem.mem_write)
    begin
      dmem[word_addr] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mem_wb.valid <= 1'b0;
    end
    else
    begin
      // Stores and x0 targets make no write-back
      mem_wb.valid <= ex_mem.valid && ex_mem.reg_write;
      if (ex_mem.valid)
      begin
        mem_wb.rd <= ex_mem.rd;
        // Load data or ALU result
        mem_wb.data <= ex_mem.mem_to_reg ? dmem[word_addr] : ex_mem.alu_result;
      end
    end
  end

endmodule

`default_nettype wire

/* src/register_file.sv */
`default_nettype none
`timescale 1ns/1ns

module register_file (
  input  logic clk,
  input  logic reset,
  input  logic [rv_isa_pkg::reg_index_width-1:0] rs1_addr,
  input  logic [rv_isa_pkg::reg_index_width-1:0] rs2_addr,
  output logic [rv_isa_pkg::xlen-1:0] rs1_data,
  output logic [rv_isa_pkg::xlen-1:0] rs2_data,
  input  logic write_enable,
  input  logic [rv_isa_pkg::reg_index_width-1:0] write_addr,
  input  logic [rv_isa_pkg::xlen-1:0] write_data
);

  // x0 through x31
  logic [rv_isa_pkg::xlen-1:0] regs [2**rv_isa_pkg::reg_index_width];

  // Combinational reads, x0 forced to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      // Whole file starts at zero
      for (int i = 0; i < 2**rv_isa_pkg::reg_index_width; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (write_enable && (write_addr != '0))
    begin
      // Write-back lands at the edge after wb goes valid
      regs[write_addr] <= write_data;
    end
  end

endmodule

`default_nettype wire
